//--- Makefile
SRCS := $(shell cat lsu_top.f)

obj_dir/Vtb_lsu_top: lsu_top.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_lsu_top -f lsu_top.f

run: obj_dir/Vtb_lsu_top
	./obj_dir/Vtb_lsu_top

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- hw/load_extend.sv
`timescale 1ns/1ps
`default_nettype none

module load_extend (
  input wire clk,
  input wire rst,
  input wire lsu_pkg::load_req_t load_req,
  output lsu_pkg::result_t load_result
);

  logic [lsu_pkg::OFFSET_W+2:0] bit_off;
  logic [7:0] byte_val;
  logic [15:0] half_val;
  lsu_pkg::word_t word_val;
  lsu_pkg::word_t ext_val;

  lsu_pkg::rob_tag_t tag_q;
  lsu_pkg::word_t value_q;

  assign bit_off = {load_req.offset, 3'b000};
  assign byte_val = load_req.line[bit_off +: 8];
  assign half_val = load_req.line[bit_off +: 16];
  assign word_val = load_req.line[bit_off +: 32];

  always_comb begin
    case (load_req.op)
      lsu_pkg::LB: ext_val = {{24{byte_val[7]}}, byte_val};
      lsu_pkg::LH: ext_val = {{16{half_val[15]}}, half_val};
      lsu_pkg::LW: ext_val = word_val;
      lsu_pkg::LBU: ext_val = {24'b0, byte_val};
      lsu_pkg::LHU: ext_val = {16'b0, half_val};
      default: ext_val = '0;
    endcase
  end

  // result register, one cycle after the hit
  always_ff @(posedge clk) begin
    if (rst) begin
      tag_q <= '0;
    end else begin
      tag_q <= load_req.dest;
    end
  end

  always_ff @(posedge clk) begin
    value_q <= ext_val;
  end

  assign load_result = '{tag: tag_q, value: value_q};

endmodule

`default_nettype wire

//--- hw/lsu_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_dcache (
  input wire clk,
  input wire rst,
  input wire head_valid,
  input wire lsu_pkg::head_t head,
  output logic head_retire,
  output lsu_pkg::load_req_t load_req,
  output logic mem_valid,
  output lsu_pkg::mem_req_t mem_req,
  input wire mem_ready,
  input wire lsu_pkg::line_t mem_line
);

  typedef enum logic [1:0] {
    IDLE,
    REFILL,
    WRITEBACK
  } state_e;

  state_e state;

  lsu_pkg::addr_tag_t tag_mem [lsu_pkg::CACHE_LINES];
  lsu_pkg::line_t data_mem [lsu_pkg::CACHE_LINES];
  logic valid [lsu_pkg::CACHE_LINES];
  logic dirty [lsu_pkg::CACHE_LINES];

  lsu_pkg::addr_tag_t addr_tag;
  lsu_pkg::index_t index;
  lsu_pkg::offset_t offset;
  logic [lsu_pkg::OFFSET_W+2:0] bit_off;
  logic hit;
  logic store;

  // address split of the head entry
  assign addr_tag = head.addr[31 -: lsu_pkg::TAG_BITS];
  assign index = head.addr[lsu_pkg::OFFSET_W +: lsu_pkg::INDEX_W];
  assign offset = head.addr[lsu_pkg::OFFSET_W-1:0];
  assign bit_off = {offset, 3'b000};

  assign hit = valid[index] && tag_mem[index] == addr_tag;
  assign store = lsu_pkg::is_store(head.op);
  assign head_retire = state == IDLE && head_valid && hit;

  // hit line goes to the extender
  always_comb begin
    load_req = '0;
    if (head_retire && !store) begin
      load_req.op = head.op;
      load_req.offset = offset;
      load_req.dest = head.dest;
      load_req.line = data_mem[index];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      mem_valid <= 1'b0;
      for (int i = 0; i < lsu_pkg::CACHE_LINES; i++) begin
        valid[i] <= 1'b0;
        dirty[i] <= 1'b0;
      end
    end else begin
      case (state)
        IDLE: begin
          if (head_valid) begin
            if (hit) begin
              if (store) begin
                case (head.op)
                  lsu_pkg::SB: data_mem[index][bit_off +: 8] <= head.data[7:0];
                  lsu_pkg::SH: data_mem[index][bit_off +: 16] <= head.data[15:0];
                  default: data_mem[index][bit_off +: 32] <= head.data;
                endcase
                dirty[index] <= 1'b1;
              end
            end else begin
              // miss, fetch the whole line
              mem_valid <= 1'b1;
              mem_req.write <= 1'b0;
              mem_req.addr <= {head.addr[31:lsu_pkg::OFFSET_W], lsu_pkg::offset_t'(0)};
              mem_req.line <= '0;
              state <= REFILL;
            end
          end
        end

        REFILL: begin
          if (mem_ready) begin
            data_mem[index] <= mem_line;
            tag_mem[index] <= addr_tag;
            valid[index] <= 1'b1;
            mem_valid <= 1'b0;
            if (valid[index] && dirty[index]) begin
              // old line still readable here, queue its write-back
              dirty[index] <= 1'b0;
              mem_req.write <= 1'b1;
              mem_req.addr <= {tag_mem[index], index, lsu_pkg::offset_t'(0)};
              mem_req.line <= data_mem[index];
              state <= WRITEBACK;
            end else begin
              state <= IDLE;
            end
          end
        end

        WRITEBACK: begin
          if (!mem_valid) begin
            mem_valid <= 1'b1;
          end else if (mem_ready) begin
            mem_valid <= 1'b0;
            state <= IDLE;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

  // request held until memory answers
  assert property (@(posedge clk) disable iff (rst)
                   mem_valid && !mem_ready |=> mem_valid && $stable(mem_req))
    else $error("mem_req changed before mem_ready");

endmodule

`default_nettype wire

//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // load/store queue
  localparam int QUEUE_DEPTH = 16;
  localparam int QPTR_W = $clog2(QUEUE_DEPTH);

  // reorder-buffer tag, zero means no producer
  localparam int TAG_W = 4;

  // direct-mapped cache geometry
  localparam int LINE_BYTES = 16;
  localparam int CACHE_LINES = 16;
  localparam int OFFSET_W = $clog2(LINE_BYTES);
  localparam int INDEX_W = $clog2(CACHE_LINES);
  localparam int TAG_BITS = 32 - INDEX_W - OFFSET_W;

  typedef logic [TAG_W-1:0] rob_tag_t;
  typedef logic [31:0] word_t;
  typedef logic [LINE_BYTES*8-1:0] line_t;

  typedef logic [QPTR_W-1:0] qptr_t;
  typedef logic [QPTR_W:0] qcount_t;
  typedef logic [OFFSET_W-1:0] offset_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_BITS-1:0] addr_tag_t;

  // loads first, so op >= SB means store
  typedef enum logic [2:0] {
    LB,
    LH,
    LW,
    LBU,
    LHU,
    SB,
    SH,
    SW
  } lsu_op_e;

  typedef struct packed {
    rob_tag_t dest;
    lsu_op_e op;
    rob_tag_t qj;
    rob_tag_t qk;
    word_t vj;
    word_t vk;
    word_t imm;
  } issue_t;

  typedef struct packed {
    rob_tag_t tag;
    word_t value;
  } result_t;

  typedef struct packed {
    lsu_op_e op;
    word_t addr;
    word_t data;
    rob_tag_t dest;
  } head_t;

  typedef struct packed {
    logic write;
    word_t addr;
    line_t line;
  } mem_req_t;

  // hit line handed to the extender, valid when dest is nonzero
  typedef struct packed {
    lsu_op_e op;
    offset_t offset;
    rob_tag_t dest;
    line_t line;
  } load_req_t;

  function automatic logic is_store(lsu_op_e op);
    return op >= SB;
  endfunction

endpackage

`default_nettype wire

//--- hw/lsu_queue.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_queue (
  input wire clk,
  input wire rst,
  input wire lsu_pkg::issue_t issue,
  input wire lsu_pkg::result_t cdb,
  input wire lsu_pkg::result_t load_fb,
  input wire lsu_pkg::rob_tag_t commit_tag,
  input wire head_retire,
  output logic head_valid,
  output lsu_pkg::head_t head,
  output logic full
);

  // per-entry control
  logic busy [lsu_pkg::QUEUE_DEPTH];
  logic committed [lsu_pkg::QUEUE_DEPTH];
  logic addr_pending [lsu_pkg::QUEUE_DEPTH];

  // per-entry operands and payload
  lsu_pkg::lsu_op_e op_q [lsu_pkg::QUEUE_DEPTH];
  lsu_pkg::rob_tag_t dest_q [lsu_pkg::QUEUE_DEPTH];
  lsu_pkg::rob_tag_t qj [lsu_pkg::QUEUE_DEPTH];
  lsu_pkg::rob_tag_t qk [lsu_pkg::QUEUE_DEPTH];
  lsu_pkg::word_t vj [lsu_pkg::QUEUE_DEPTH];
  lsu_pkg::word_t vk [lsu_pkg::QUEUE_DEPTH];
  lsu_pkg::word_t imm [lsu_pkg::QUEUE_DEPTH];

  lsu_pkg::qptr_t head_ptr;
  lsu_pkg::qptr_t tail_ptr;
  lsu_pkg::qcount_t count;

  logic issue_en;
  logic calc_found;
  lsu_pkg::qptr_t calc_idx;

  function automatic lsu_pkg::qptr_t next_ptr(lsu_pkg::qptr_t p);
    return (p == lsu_pkg::qptr_t'(lsu_pkg::QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // pick up a value from either broadcast, otherwise keep tag and value
  function automatic lsu_pkg::result_t capture(lsu_pkg::rob_tag_t q, lsu_pkg::word_t v,
                                               lsu_pkg::result_t bus_a,
                                               lsu_pkg::result_t bus_b);
    if (bus_a.tag != '0 && q == bus_a.tag) begin
      return '{tag: '0, value: bus_a.value};
    end
    if (bus_b.tag != '0 && q == bus_b.tag) begin
      return '{tag: '0, value: bus_b.value};
    end
    return '{tag: q, value: v};
  endfunction

  assign issue_en = issue.dest != '0;
  assign full = count >= lsu_pkg::qcount_t'(lsu_pkg::QUEUE_DEPTH - 1);

  assign head_valid = busy[head_ptr] && qj[head_ptr] == '0 && qk[head_ptr] == '0 &&
                      !addr_pending[head_ptr] &&
                      (!lsu_pkg::is_store(op_q[head_ptr]) || committed[head_ptr]);

  assign head = '{op: op_q[head_ptr], addr: vj[head_ptr], data: vk[head_ptr],
                  dest: dest_q[head_ptr]};

  // lowest busy entry with a ready base and no address yet
  always_comb begin
    calc_found = 1'b0;
    calc_idx = '0;
    for (int i = 0; i < lsu_pkg::QUEUE_DEPTH; i++) begin
      if (!calc_found && busy[i] && qj[i] == '0 && addr_pending[i]) begin
        calc_found = 1'b1;
        calc_idx = lsu_pkg::qptr_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
      tail_ptr <= '0;
      count <= '0;
      for (int i = 0; i < lsu_pkg::QUEUE_DEPTH; i++) begin
        busy[i] <= 1'b0;
        committed[i] <= 1'b0;
        addr_pending[i] <= 1'b0;
      end
    end else begin
      // operand wakeup and commit marking
      for (int i = 0; i < lsu_pkg::QUEUE_DEPTH; i++) begin
        {qj[i], vj[i]} <= capture(qj[i], vj[i], cdb, load_fb);
        {qk[i], vk[i]} <= capture(qk[i], vk[i], cdb, load_fb);
        if (commit_tag != '0 && busy[i] && dest_q[i] == commit_tag) begin
          committed[i] <= 1'b1;
        end
      end

      // base + imm, one entry per cycle
      if (calc_found) begin
        vj[calc_idx] <= vj[calc_idx] + imm[calc_idx];
        addr_pending[calc_idx] <= 1'b0;
      end

      if (issue_en) begin
        op_q[tail_ptr] <= issue.op;
        dest_q[tail_ptr] <= issue.dest;
        imm[tail_ptr] <= issue.imm;
        {qj[tail_ptr], vj[tail_ptr]} <= capture(issue.qj, issue.vj, cdb, load_fb);
        {qk[tail_ptr], vk[tail_ptr]} <= capture(issue.qk, issue.vk, cdb, load_fb);
        busy[tail_ptr] <= 1'b1;
        committed[tail_ptr] <= 1'b0;
        addr_pending[tail_ptr] <= 1'b1;
        tail_ptr <= next_ptr(tail_ptr);
      end

      if (head_retire) begin
        busy[head_ptr] <= 1'b0;
        head_ptr <= next_ptr(head_ptr);
      end

      case ({issue_en, head_retire})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // issue logic must honour full
  assert property (@(posedge clk) disable iff (rst) issue.dest != '0 |-> !full)
    else $error("issue while queue full");

  // cache only retires an executable head
  assert property (@(posedge clk) disable iff (rst) head_retire |-> head_valid)
    else $error("head_retire without head_valid");

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input wire clk,
  input wire rst,
  input wire lsu_pkg::issue_t issue,
  input wire lsu_pkg::result_t cdb,
  input wire lsu_pkg::rob_tag_t commit_tag,
  output lsu_pkg::result_t load_result,
  output logic mem_valid,
  output lsu_pkg::mem_req_t mem_req,
  input wire mem_ready,
  input wire lsu_pkg::line_t mem_line,
  output logic full
);

  logic head_valid;
  lsu_pkg::head_t head;
  logic head_retire;
  lsu_pkg::load_req_t load_req;

  // load results also wake waiting queue entries
  lsu_queue u_queue (
    .clk(clk),
    .rst(rst),
    .issue(issue),
    .cdb(cdb),
    .load_fb(load_result),
    .commit_tag(commit_tag),
    .head_retire(head_retire),
    .head_valid(head_valid),
    .head(head),
    .full(full)
  );

  lsu_dcache u_dcache (
    .clk(clk),
    .rst(rst),
    .head_valid(head_valid),
    .head(head),
    .head_retire(head_retire),
    .load_req(load_req),
    .mem_valid(mem_valid),
    .mem_req(mem_req),
    .mem_ready(mem_ready),
    .mem_line(mem_line)
  );

  load_extend u_extend (
    .clk(clk),
    .rst(rst),
    .load_req(load_req),
    .load_result(load_result)
  );

endmodule

`default_nettype wire

//--- lsu_top.f
hw/lsu_pkg.sv
hw/lsu_queue.sv
hw/lsu_dcache.sv
hw/load_extend.sv
hw/lsu_top.sv
testbench/tb_mem_model.sv
testbench/tb_lsu_top.sv

//--- testbench/tb_lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

  logic clk = 1'b0;
  logic rst;
  lsu_pkg::issue_t issue;
  lsu_pkg::result_t cdb;
  lsu_pkg::rob_tag_t commit_tag;
  lsu_pkg::result_t load_result;
  logic mem_valid;
  lsu_pkg::mem_req_t mem_req;
  logic mem_ready;
  lsu_pkg::line_t mem_line;
  logic full;

  // byte-level reference, updated at store commit
  logic [7:0] ref_mem [lsu_pkg::word_t];
  logic pending [16];
  lsu_pkg::lsu_op_e rec_op [16];
  lsu_pkg::word_t rec_addr [16];
  lsu_pkg::word_t rec_data [16];
  logic hold_loads;
  int cycles;
  int issued;
  logic [31:0] rng;
  lsu_pkg::rob_tag_t mon_tag;
  lsu_pkg::word_t mon_exp;
  lsu_pkg::word_t addr;
  lsu_pkg::lsu_op_e op;
  lsu_pkg::rob_tag_t d;

  always #2 clk = ~clk;

  lsu_top dut (.clk(clk), .rst(rst), .issue(issue), .cdb(cdb), .commit_tag(commit_tag),
               .load_result(load_result), .mem_valid(mem_valid), .mem_req(mem_req),
               .mem_ready(mem_ready), .mem_line(mem_line), .full(full));

  tb_mem_model mem (.clk(clk), .rst(rst), .mem_valid(mem_valid), .mem_req(mem_req),
                    .mem_ready(mem_ready), .mem_line(mem_line));

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // same initial content as the memory model
  function automatic lsu_pkg::word_t fill_word(lsu_pkg::word_t a);
    return (a * 32'h9e3779b1) ^ {a[15:0], a[31:16]};
  endfunction

  function automatic logic [7:0] ref_byte(lsu_pkg::word_t a);
    lsu_pkg::word_t w;
    if (ref_mem.exists(a)) begin
      return ref_mem[a];
    end
    w = fill_word({a[31:2], 2'b00});
    return w[{a[1:0], 3'b000} +: 8];
  endfunction

  function automatic lsu_pkg::line_t ref_line(lsu_pkg::word_t a);
    lsu_pkg::line_t l;
    for (int k = 0; k < 16; k++) begin
      l[8*k +: 8] = ref_byte({a[31:4], 4'b0000} + lsu_pkg::word_t'(k));
    end
    return l;
  endfunction

  function automatic lsu_pkg::word_t expect_load(lsu_pkg::lsu_op_e o, lsu_pkg::word_t a);
    logic [7:0] b;
    logic [15:0] h;
    b = ref_byte(a);
    h = {ref_byte(a + 32'd1), b};
    case (o)
      lsu_pkg::LB: return {{24{b[7]}}, b};
      lsu_pkg::LH: return {{16{h[15]}}, h};
      lsu_pkg::LBU: return {24'b0, b};
      lsu_pkg::LHU: return {16'b0, h};
      default: return {ref_byte(a + 32'd3), ref_byte(a + 32'd2), h};
    endcase
  endfunction

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  // base is the value the address uses, even when it arrives later on cdb
  task automatic send_issue(lsu_pkg::lsu_op_e o, lsu_pkg::rob_tag_t dst, lsu_pkg::rob_tag_t qj,
                            lsu_pkg::word_t base, lsu_pkg::word_t data, lsu_pkg::word_t imm);
    @(posedge clk);
    issue <= '{dest: dst, op: o, qj: qj, qk: '0, vj: (qj != '0) ? 32'hdeadbeef : base,
               vk: data, imm: imm};
    rec_op[dst] = o;
    rec_addr[dst] = base + imm;
    rec_data[dst] = data;
    pending[dst] = !(o inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW});
    issued++;
    @(posedge clk);
    issue <= '0;
  endtask

  task automatic commit_store(lsu_pkg::rob_tag_t t);
    int n;
    @(posedge clk);
    commit_tag <= t;
    n = (rec_op[t] == lsu_pkg::SB) ? 1 : (rec_op[t] == lsu_pkg::SH) ? 2 : 4;
    for (int k = 0; k < n; k++) begin
      ref_mem[rec_addr[t] + lsu_pkg::word_t'(k)] = rec_data[t][8*k +: 8];
    end
    @(posedge clk);
    commit_tag <= '0;
  endtask

  task automatic wait_load(lsu_pkg::rob_tag_t t);
    while (pending[t]) @(posedge clk);
  endtask

  task automatic wait_empty();
    while (dut.u_queue.count != '0) @(posedge clk);
  endtask

  task automatic check_idle();
    assert (!mem_valid && load_result.tag == '0 && !full)
      else report_failure($sformatf("MISMATCH reset state mem_valid=%0h tag=%0h full=%0h",
                                    mem_valid, load_result.tag, full));
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > 200 * (issued + 2)) begin
      report_failure("watchdog timeout, DUT stopped making progress");
    end
  end

  // load results and write-back lines against the reference
  always @(posedge clk) begin
    if (!rst && load_result.tag != '0) begin
      mon_tag = load_result.tag;
      assert (pending[mon_tag] && !hold_loads)
        else report_failure($sformatf("unexpected load result for tag %0h", mon_tag));
      mon_exp = expect_load(rec_op[mon_tag], rec_addr[mon_tag]);
      assert (load_result.value == mon_exp)
        else report_failure($sformatf("MISMATCH load_result.value tag %0h got %08h exp %08h",
                                      mon_tag, load_result.value, mon_exp));
      pending[mon_tag] = 1'b0;
    end
    if (!rst && mem_valid && mem_ready && mem_req.write) begin
      assert (mem_req.line == ref_line(mem_req.addr))
        else report_failure($sformatf("MISMATCH mem_req.line addr %08h got %032h exp %032h",
                                      mem_req.addr, mem_req.line, ref_line(mem_req.addr)));
    end
  end

  initial begin
    rst = 1'b1;
    issue = '0;
    cdb = '0;
    commit_tag = '0;
    hold_loads = 1'b0;
    cycles = 0;
    issued = 0;
    rng = 32'hf831;
    for (int i = 0; i < 16; i++) pending[i] = 1'b0;
    for (int i = 0; i < 8; i++) begin
      @(posedge clk);
      if (i > 0) check_idle();
    end
    rst <= 1'b0;
    @(posedge clk);
    check_idle();

    // random loads with ready operands
    for (int i = 0; i < 20; i++) begin
      rng = xorshift(rng);
      op = lsu_pkg::lsu_op_e'(i % 5);
      addr = {20'h0, rng[11:2], 2'b00};
      if (op == lsu_pkg::LH || op == lsu_pkg::LHU) addr = addr + {30'b0, rng[13], 1'b0};
      if (op == lsu_pkg::LB || op == lsu_pkg::LBU) addr = addr + {30'b0, rng[13:12]};
      d = lsu_pkg::rob_tag_t'(1 + i % 14);
      send_issue(op, d, '0, addr & 32'hffff_fff0, '0, {28'b0, addr[3:0]});
      wait_load(d);
    end

    // load behind an uncommitted store, negative bytes
    send_issue(lsu_pkg::SW, 4'd1, '0, 32'h200, 32'h80f1ff7e, 32'h0);
    hold_loads = 1'b1;
    send_issue(lsu_pkg::LB, 4'd2, '0, 32'h200, '0, 32'h1);
    repeat (30) @(posedge clk);
    hold_loads = 1'b0;
    commit_store(4'd1);
    wait_load(4'd2);
    send_issue(lsu_pkg::LBU, 4'd3, '0, 32'h200, '0, 32'h3);
    send_issue(lsu_pkg::LH, 4'd4, '0, 32'h200, '0, 32'h2);
    send_issue(lsu_pkg::LHU, 4'd5, '0, 32'h200, '0, 32'h0);
    send_issue(lsu_pkg::LW, 4'd6, '0, 32'h200, '0, 32'h0);
    wait_load(4'd6);

    // base waits on a cdb broadcast
    send_issue(lsu_pkg::LW, 4'd3, 4'd15, 32'h340, '0, 32'h8);
    repeat (12) @(posedge clk);
    assert (pending[3]) else report_failure("load completed before its base was broadcast");
    @(posedge clk);
    cdb <= '{tag: 4'd15, value: 32'h340};
    @(posedge clk);
    cdb <= '0;
    wait_load(4'd3);

    // same index, different tags, dirty victim
    send_issue(lsu_pkg::SW, 4'd7, '0, 32'h1010, 32'hc0ffee11, 32'h0);
    commit_store(4'd7);
    wait_empty();
    send_issue(lsu_pkg::LW, 4'd8, '0, 32'h2010, '0, 32'h4);
    send_issue(lsu_pkg::LH, 4'd9, '0, 32'h3010, '0, 32'h8);
    send_issue(lsu_pkg::LW, 4'd10, '0, 32'h1010, '0, 32'h0);
    wait_load(4'd10);

    // fill the queue with uncommitted stores
    for (int i = 1; i < lsu_pkg::QUEUE_DEPTH; i++) begin
      rng = xorshift(rng);
      send_issue(lsu_pkg::SB, lsu_pkg::rob_tag_t'(i), '0, 32'h4000, rng, 32'(i));
    end
    @(posedge clk);
    assert (full) else report_failure($sformatf("MISMATCH full got %0h exp 1", full));
    for (int i = 1; i < lsu_pkg::QUEUE_DEPTH; i++) begin
      commit_store(lsu_pkg::rob_tag_t'(i));
    end
    wait_empty();
    @(posedge clk);
    assert (!full) else report_failure($sformatf("MISMATCH full got %0h exp 0", full));
    send_issue(lsu_pkg::LW, 4'd1, '0, 32'h4000, '0, 32'h4);
    send_issue(lsu_pkg::LW, 4'd2, '0, 32'h4000, '0, 32'hc);
    wait_load(4'd2);
    repeat (4) @(posedge clk);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input wire clk,
  input wire rst,
  input wire mem_valid,
  input wire lsu_pkg::mem_req_t mem_req,
  output logic mem_ready,
  output lsu_pkg::line_t mem_line
);

  // lines written back so far, keyed by line address
  lsu_pkg::line_t shadow [logic [27:0]];
  logic [31:0] rng;
  logic busy;
  int wait_cycles;

  function automatic logic [31:0] xorshift(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic lsu_pkg::word_t fill_word(lsu_pkg::word_t addr);
    return (addr * 32'h9e3779b1) ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic lsu_pkg::line_t read_line(lsu_pkg::word_t addr);
    lsu_pkg::line_t l;
    if (shadow.exists(addr[31:4])) begin
      return shadow[addr[31:4]];
    end
    for (int w = 0; w < 4; w++) begin
      l[w*32 +: 32] = fill_word({addr[31:4], 4'b0000} + lsu_pkg::word_t'(w * 4));
    end
    return l;
  endfunction

  // random 1 to 8 cycle answer per request
  always @(posedge clk) begin
    if (rst) begin
      mem_ready <= 1'b0;
      mem_line <= '0;
      busy <= 1'b0;
      wait_cycles <= 0;
      rng <= 32'hf831;
    end else if (mem_ready) begin
      mem_ready <= 1'b0;
    end else if (busy) begin
      if (wait_cycles <= 1) begin
        mem_ready <= 1'b1;
        busy <= 1'b0;
        if (mem_req.write) begin
          shadow[mem_req.addr[31:4]] = mem_req.line;
        end else begin
          mem_line <= read_line(mem_req.addr);
        end
      end else begin
        wait_cycles <= wait_cycles - 1;
      end
    end else if (mem_valid) begin
      busy <= 1'b1;
      wait_cycles <= int'(rng[2:0]) + 1;
      rng <= xorshift(rng);
    end
  end

endmodule

`default_nettype wire
